//--- corr_pkg.sv
package corr_pkg;

   // --------------------
   // Array geometry
   // --------------------
   localparam int unsigned NANT  = 4;                    // Antennas feeding the correlator
   localparam int unsigned NPAIR = 6;                    // Baselines, every unordered pair
   localparam int unsigned AIDX_W = $clog2(NANT);        // Antenna index width

   // Baseline table, pair p correlates PAIR_A[p] against PAIR_B[p]
   localparam logic [AIDX_W-1:0] PAIR_A [NPAIR] = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd2};
   localparam logic [AIDX_W-1:0] PAIR_B [NPAIR] = '{2'd1, 2'd2, 2'd3, 2'd2, 2'd3, 2'd3};

   // --------------------
   // Integration block
   // --------------------
   localparam int unsigned BLOCK_LEN = 8;                // Valid samples per bank
   localparam int unsigned CNT_W     = $clog2(BLOCK_LEN); // Sample counter width
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLOCK_LEN - 1); // Last sample of a block

   // One spare bit so a full block never hits all-ones
   localparam int unsigned ACC_W = CNT_W + 1;

   // --------------------
   // Read-back bus map
   // --------------------
   // Address = pair * 2 + part, part 0 is real and 1 is imaginary
   localparam int unsigned ADDR_W = 4;                   // Bus address width
   localparam int unsigned DATA_W = 8;                   // Bus data width, counts zero-extended
   localparam logic [ADDR_W-1:0] NADDR = ADDR_W'(2 * NPAIR); // First unmapped address

endpackage

//--- hilbert_split.sv
`timescale 1ns/1ps

// Cheap quadrature split, the previous sample stands in for the 90 degree term
module hilbert_split (
   input  logic                        clk_i,
   input  logic                        reset_i,
   input  logic                        en_i,      // Antenna sample strobe
   input  logic [corr_pkg::NANT-1:0]   ax_i,      // One-bit sign samples
   output logic                        valid_o,   // Re/im pair is fresh
   output logic [corr_pkg::NANT-1:0]   re_o,      // Current sample
   output logic [corr_pkg::NANT-1:0]   im_o       // Previous valid sample
);

   // --------------------
   // Strobe and history
   // --------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_o <= 1'b0;                     // Nothing pending
         re_o    <= '0;                       // Seeds a zero first im
      end else begin
         valid_o <= en_i;                     // One cycle behind en_i
         if (en_i) begin
            re_o <= ax_i;                     // Latest sample is the real part
         end
      end
   end

   // Imaginary part trails by one valid sample, holds across idle gaps
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         im_o <= '0;                          // No earlier sample yet
      end else if (en_i) begin
         im_o <= re_o;                        // Sample held before this one
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Back-to-back valids need back-to-back enables
   assert property (@(posedge clk_i) disable iff (reset_i)
      valid_o && $past(valid_o) |-> $past(en_i) && $past(en_i, 2));

endmodule

//--- bank_switch.sv
`timescale 1ns/1ps

// Block timer, swaps accumulator banks every BLOCK_LEN valid samples
module bank_switch (
   input  logic clk_i,
   input  logic reset_i,
   input  logic valid_i,        // Sample strobe from the quadrature split
   output logic bank_o,         // Bank currently accumulating
   output logic clear_o,        // Next sample loads instead of adds
   output logic block_done_o    // Finished bank is readable
);

   logic [corr_pkg::CNT_W-1:0] cnt_q;     // Samples taken in this block
   logic                       wrap;      // Last sample of the block
   logic                       swap_q;    // Swap happened last edge

   assign wrap = valid_i && (cnt_q == corr_pkg::CNT_LAST);

   // --------------------
   // Sample count and bank
   // --------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q        <= '0;
         bank_o       <= 1'b0;            // Start filling bank 0
         clear_o      <= 1'b1;            // First sample ever loads
         swap_q       <= 1'b0;
         block_done_o <= 1'b0;
      end else begin
         swap_q       <= wrap;
         block_done_o <= swap_q;          // Flag after the final update settles
         if (valid_i) begin
            cnt_q   <= wrap ? '0 : cnt_q + 1'b1;
            // Armed by the wrap, dropped after the first sample of the new block
            clear_o <= wrap;
         end
         if (wrap) begin
            bank_o <= ~bank_o;            // Flip lands with the last accumulation
         end
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Blocks are at least one sample apart so done never repeats
   assert property (@(posedge clk_i) disable iff (reset_i)
      block_done_o |=> !block_done_o);

endmodule

//--- correlator_block.sv
`timescale 1ns/1ps

// Two-bank agreement counters for every baseline in the pair table
module correlator_block (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          valid_i,     // Fresh re/im pair
   input  logic [corr_pkg::NANT-1:0]     re_i,        // Real sign bits
   input  logic [corr_pkg::NANT-1:0]     im_i,        // Imaginary sign bits
   input  logic                          bank_i,      // Bank being filled
   input  logic                          clear_i,     // Zero input on this sample
   input  logic [corr_pkg::ADDR_W-1:0]   rd_addr_i,   // Read-back address
   output logic [corr_pkg::ACC_W-1:0]    rd_data_o    // Count from the idle bank
);

   // --------------------
   // Storage
   // --------------------
   logic [corr_pkg::ACC_W-1:0] acc_re [2][corr_pkg::NPAIR];   // Real agreement counts
   logic [corr_pkg::ACC_W-1:0] acc_im [2][corr_pkg::NPAIR];   // Imaginary agreement counts

   logic [corr_pkg::ACC_W-1:0] add_re [corr_pkg::NPAIR];      // Per-pair increments
   logic [corr_pkg::ACC_W-1:0] add_im [corr_pkg::NPAIR];

   logic [corr_pkg::ADDR_W-2:0] rd_pair;   // Baseline index of the read
   logic                        rd_bank;   // Bank not being filled

   // --------------------
   // One-bit correlation
   // --------------------
   for (genvar p = 0; p < corr_pkg::NPAIR; p++) begin : g_pair
      // XNOR of signs, 1 when the two antennas agree
      assign add_re[p] = {{(corr_pkg::ACC_W-1){1'b0}},
                          re_i[corr_pkg::PAIR_A[p]] ~^ re_i[corr_pkg::PAIR_B[p]]};
      assign add_im[p] = {{(corr_pkg::ACC_W-1){1'b0}},
                          re_i[corr_pkg::PAIR_A[p]] ~^ im_i[corr_pkg::PAIR_B[p]]};
   end

   // --------------------
   // Accumulate
   // --------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int b = 0; b < 2; b++) begin
            for (int p = 0; p < corr_pkg::NPAIR; p++) begin
               acc_re[b][p] <= '0;
               acc_im[b][p] <= '0;
            end
         end
      end else if (valid_i) begin
         for (int p = 0; p < corr_pkg::NPAIR; p++) begin
            // Clear feeds a zero instead of the old count
            acc_re[bank_i][p] <= (clear_i ? '0 : acc_re[bank_i][p]) + add_re[p];
            acc_im[bank_i][p] <= (clear_i ? '0 : acc_im[bank_i][p]) + add_im[p];
         end
      end
   end

   // --------------------
   // Read port
   // --------------------
   assign rd_pair = rd_addr_i[corr_pkg::ADDR_W-1:1];   // Drop the re/im select
   assign rd_bank = ~bank_i;                           // Finished bank only

   always_comb begin
      rd_data_o = '0;                                  // Unmapped reads give zero
      if (rd_addr_i < corr_pkg::NADDR) begin
         if (rd_addr_i[0]) begin
            rd_data_o = acc_im[rd_bank][rd_pair];
         end else begin
            rd_data_o = acc_re[rd_bank][rd_pair];
         end
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Holds only while the bank switch clears every block on time
   for (genvar b = 0; b < 2; b++) begin : g_chk_bank
      for (genvar p = 0; p < corr_pkg::NPAIR; p++) begin : g_chk_pair
         assert property (@(posedge clk_i) disable iff (reset_i)
            (acc_re[b][p] != '1) && (acc_im[b][p] != '1));
      end
   end

endmodule

//--- visibility_readback.sv
`timescale 1ns/1ps

// Strobe/acknowledge read port onto the idle accumulator bank
module visibility_readback (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          stb_i,       // Read request, one per cycle max
   input  logic [corr_pkg::ADDR_W-1:0]   adr_i,       // Visibility address
   input  logic [corr_pkg::ACC_W-1:0]    rd_data_i,   // Count from the correlator
   output logic [corr_pkg::ADDR_W-1:0]   rd_addr_o,   // Address to the correlator
   output logic                          ack_o,       // Data valid, one cycle after stb
   output logic [corr_pkg::DATA_W-1:0]   dat_o        // Zero-extended count
);

   // Correlator read is combinational, so the address goes straight through
   assign rd_addr_o = adr_i;

   // --------------------
   // Acknowledge
   // --------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_o <= 1'b0;                    // No transfer in flight
      end else begin
         ack_o <= stb_i;                   // Single-cycle pulse per strobe
      end
   end

   // --------------------
   // Data register
   // --------------------
   always_ff @(posedge clk_i) begin
      if (stb_i) begin
         dat_o <= {{(corr_pkg::DATA_W - corr_pkg::ACC_W){1'b0}}, rd_data_i};
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Unmapped addresses come back as zero through the correlator read port
   assert property (@(posedge clk_i) disable iff (reset_i)
      stb_i && (adr_i >= corr_pkg::NADDR) |=> ack_o && (dat_o == '0));

endmodule

//--- correlator_top.sv
`timescale 1ns/1ps

// Four-antenna one-bit correlator with banked read-back
module correlator_top (
   input  logic                          clk_i,
   input  logic                          reset_i,

   // Antenna samples
   input  logic                          en_i,          // Sample strobe
   input  logic [corr_pkg::NANT-1:0]     ax_i,          // One-bit antenna data

   // Read-back bus
   input  logic                          stb_i,         // Read strobe
   input  logic [corr_pkg::ADDR_W-1:0]   adr_i,         // Visibility address
   output logic                          ack_o,         // Read acknowledge
   output logic [corr_pkg::DATA_W-1:0]   dat_o,         // Read data

   output logic                          block_done_o   // New bank ready
);

   logic                          valid;     // Quadrature pair strobe
   logic [corr_pkg::NANT-1:0]     re;        // Real sign bits
   logic [corr_pkg::NANT-1:0]     im;        // Imaginary sign bits
   logic                          bank;      // Bank being filled
   logic                          clear;     // Load on next sample
   logic [corr_pkg::ADDR_W-1:0]   rd_addr;   // Read-back address
   logic [corr_pkg::ACC_W-1:0]    rd_data;   // Raw count

   // --------------------
   // Quadrature split
   // --------------------
   hilbert_split u_hilbert (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .en_i    (en_i),
      .ax_i    (ax_i),
      .valid_o (valid),
      .re_o    (re),
      .im_o    (im)
   );

   // --------------------
   // Bank control
   // --------------------
   bank_switch u_switch (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .valid_i      (valid),
      .bank_o       (bank),
      .clear_o      (clear),
      .block_done_o (block_done_o)
   );

   // --------------------
   // Correlator
   // --------------------
   correlator_block u_corr (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .valid_i   (valid),
      .re_i      (re),
      .im_i      (im),
      .bank_i    (bank),
      .clear_i   (clear),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   // --------------------
   // Bus port
   // --------------------
   visibility_readback u_readback (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .stb_i     (stb_i),
      .adr_i     (adr_i),
      .rd_data_i (rd_data),
      .rd_addr_o (rd_addr),
      .ack_o     (ack_o),
      .dat_o     (dat_o)
   );

endmodule

//--- tb_correlator_top.sv
`timescale 1ns/1ps

module tb_correlator_top;

   // --------------------
   // Test geometry
   // --------------------
   localparam int NBLK      = 10;                       // Blocks in the stimulus table
   localparam int NFIXED    = 4;                        // Hand-written rows, rest random
   localparam int NMAP      = int'(corr_pkg::NADDR);    // Mapped visibility addresses
   localparam int NADR_ALL  = 1 << corr_pkg::ADDR_W;    // Whole bus address space
   localparam int WATCH_CYC = NBLK * 40 + 100;          // Clock periods before giving up

   logic                          clk = 1'b0;
   logic                          reset;
   logic                          en;
   logic [corr_pkg::NANT-1:0]     ax;
   logic                          stb;
   logic [corr_pkg::ADDR_W-1:0]   adr;
   logic                          ack;
   logic [corr_pkg::DATA_W-1:0]   dat;
   logic                          block_done;

   // Stimulus rows and model counts per block
   logic [corr_pkg::NANT-1:0]     blk_word [NBLK][corr_pkg::BLOCK_LEN];
   logic                          blk_gap  [NBLK];        // Idle cycles between samples
   logic [corr_pkg::DATA_W-1:0]   blk_exp  [NBLK][NMAP];

   logic [corr_pkg::DATA_W-1:0]   shown [NMAP];           // Expected idle-bank contents
   logic                          rd_pend;                // Strobe issued last cycle
   logic [corr_pkg::DATA_W-1:0]   rd_exp;                 // Data due with that ack
   int                            rd_adr;
   int                            rd_next;                // Rolling address for busy reads
   logic [31:0]                   rng;

   correlator_top uut (
      .clk_i        (clk),
      .reset_i      (reset),
      .en_i         (en),
      .ax_i         (ax),
      .stb_i        (stb),
      .adr_i        (adr),
      .ack_o        (ack),
      .dat_o        (dat),
      .block_done_o (block_done)
   );

   always #10 clk = ~clk;                                 // 20 ns period

   // --------------------
   // Compare helpers
   // --------------------
   task automatic check_count(input string name, input logic [corr_pkg::DATA_W-1:0] got,
                              input logic [corr_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "Count mismatch on %s", name);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "Flag mismatch on %s", name);
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // --------------------
   // Stimulus table
   // --------------------
   task automatic build_table();
      int r;
      int i;
      blk_word[0] = '{4'h0, 4'hF, 4'h5, 4'hA, 4'h3, 4'hC, 4'h6, 4'h9};
      blk_gap[0]  = 1'b0;
      blk_word[1] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'hE, 4'hD, 4'hB, 4'h9};
      blk_gap[1]  = 1'b0;
      // Same words and same carried sample as row 1, only gaps differ
      blk_word[2] = blk_word[1];
      blk_gap[2]  = 1'b1;
      blk_word[3] = '{4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'h0, 4'h0, 4'h0};
      blk_gap[3]  = 1'b1;
      rng = 32'd84;                                        // Fixed seed
      for (r = NFIXED; r < NBLK; r++) begin
         for (i = 0; i < corr_pkg::BLOCK_LEN; i++) begin
            rng = xorshift32(rng);
            blk_word[r][i] = rng[corr_pkg::NANT-1:0];
         end
         rng = xorshift32(rng);
         blk_gap[r] = rng[8];
      end
   endtask

   // Agreement counts per pair, previous sample carried across blocks
   task automatic build_expected();
      logic [corr_pkg::NANT-1:0] prev;
      logic [corr_pkg::NANT-1:0] cur;
      int r;
      int i;
      int p;
      int a;
      prev = '0;                                           // Nothing sampled before reset
      for (r = 0; r < NBLK; r++) begin
         for (a = 0; a < NMAP; a++) begin
            blk_exp[r][a] = '0;
         end
         for (i = 0; i < corr_pkg::BLOCK_LEN; i++) begin
            cur = blk_word[r][i];
            for (p = 0; p < corr_pkg::NPAIR; p++) begin
               if (cur[corr_pkg::PAIR_A[p]] == cur[corr_pkg::PAIR_B[p]]) begin
                  blk_exp[r][2*p] = blk_exp[r][2*p] + corr_pkg::DATA_W'(1);
               end
               if (cur[corr_pkg::PAIR_A[p]] == prev[corr_pkg::PAIR_B[p]]) begin
                  blk_exp[r][2*p+1] = blk_exp[r][2*p+1] + corr_pkg::DATA_W'(1);
               end
            end
            prev = cur;
         end
      end
   endtask

   // --------------------
   // Cycle and bus helpers
   // --------------------
   // Advance one clock, then check the ack owed by the last strobe
   task automatic step();
      @(posedge clk);
      #2;
      check_flag("ack_o", ack, rd_pend);
      if (rd_pend) begin
         check_count($sformatf("dat_o adr 0x%0h", rd_adr), dat, rd_exp);
      end
      rd_pend = 1'b0;
      stb     = 1'b0;                                      // Default idle next cycle
      en      = 1'b0;
   endtask

   task automatic issue_read(input int a);
      adr     = corr_pkg::ADDR_W'(a);
      stb     = 1'b1;
      rd_pend = 1'b1;
      rd_adr  = a;
      rd_exp  = (a < NMAP) ? shown[a] : '0;                // Unmapped reads give zero
   endtask

   // Strobe every address back to back, checking done stays low
   task automatic read_all();
      int a;
      for (a = 0; a < NADR_ALL; a++) begin
         issue_read(a);
         step();
         check_flag("block_done_o", block_done, 1'b0);
      end
   endtask

   // --------------------
   // One block
   // --------------------
   task automatic run_block(input int r);
      int i;
      int g;
      int a;
      for (i = 0; i < corr_pkg::BLOCK_LEN; i++) begin
         if (blk_gap[r] && (i > 0)) begin
            for (g = 0; g < 1 + (i % 2); g++) begin
               issue_read(rd_next % NADR_ALL);             // Bus stays busy through the gap
               rd_next++;
               step();
               check_flag("block_done_o", block_done, 1'b0);
            end
         end
         en = 1'b1;
         ax = blk_word[r][i];
         issue_read(rd_next % NADR_ALL);                   // Old bank while filling
         rd_next++;
         step();
         check_flag("block_done_o", block_done, 1'b0);
      end
      // Done lands 3 cycles after the last sample strobe
      step();
      check_flag("block_done_o", block_done, 1'b0);
      step();
      check_flag("block_done_o", block_done, 1'b1);
      step();
      check_flag("block_done_o", block_done, 1'b0);        // Single-cycle pulse
      for (a = 0; a < NMAP; a++) begin
         shown[a] = blk_exp[r][a];
      end
      read_all();
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      reset   = 1'b1;
      en      = 1'b0;
      ax      = '0;
      stb     = 1'b0;
      adr     = '0;
      rd_pend = 1'b0;
      rd_exp  = '0;
      rd_adr  = 0;
      rd_next = 0;
      build_table();
      build_expected();
      for (int a = 0; a < NMAP; a++) begin
         shown[a] = '0;                                    // Both banks empty after reset
      end
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      check_flag("ack_o", ack, 1'b0);
      check_flag("block_done_o", block_done, 1'b0);
      read_all();
      for (int r = 0; r < NBLK; r++) begin
         run_block(r);
      end
      $display("NO ERRORS");
      $finish;
   end

   // Hung pipeline guard
   initial begin
      repeat (WATCH_CYC) @(posedge clk);
      $display("ERRORS FOUND");
      $fatal(1, "Timeout, the test sequence did not finish in %0d clock cycles", WATCH_CYC);
   end

endmodule

//--- verilog.f
corr_pkg.sv
hilbert_split.sv
bank_switch.sv
correlator_block.sv
visibility_readback.sv
correlator_top.sv
tb_correlator_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the correlator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module tb_correlator_top \
   -o tb_sim

./obj_dir/tb_sim
